// File: hdl/core_monitor.sv
// core LP conflict monitor
`timescale 1ns/1ns
`default_nettype none

module core_monitor
   import pdes_event_pkg::*;
   import pdes_core_pkg::*;
#(
   parameter int NUM_CORE = 4
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  send_vld,
   input  wire core_id_t        send_core,
   input  wire lp_id_t          send_lp,
   input  wire evt_time_t       send_time,
   input  wire                  ret_vld,
   input  wire core_id_t        ret_core,
   input  wire lp_id_t          ret_lp,
   output logic [NUM_CORE-1:0]  stall
);

   localparam int NODES = 2 * NUM_CORE;

   // per-core table
   lp_id_t              tbl_lp   [NUM_CORE];
   evt_time_t           tbl_time [NUM_CORE];
   logic [NUM_CORE-1:0] active;

   logic [NUM_CORE-1:0] send_match;
   logic [NUM_CORE-1:0] ret_match;

   // min tree in heap order
   // node 1 is the root, leaf of core m sits at NUM_CORE + m
   logic                node_vld  [1:NODES-1];
   evt_time_t           node_time [1:NODES-1];
   core_id_t            node_id   [1:NODES-1];

   logic                rel_vld;
   core_id_t            rel_id;

   // lp and timestamp of the event on each core
   always_ff @(posedge clk) begin
      if (send_vld) begin
         tbl_lp[send_core]   <= send_lp;
         tbl_time[send_core] <= send_time;
      end
   end

   // active flags
   // send and return hit different cores, both may land in one edge
   always_ff @(posedge clk) begin
      if (reset) begin
         active <= '0;
      end else begin
         for (int c = 0; c < NUM_CORE; c++) begin
            if (send_vld && (send_core == core_id_t'(c))) begin
               active[c] <= 1'b1;
            end else if (ret_vld && (ret_core == core_id_t'(c))) begin
               active[c] <= 1'b0;
            end
         end
      end
   end

   generate
      for (genvar m = 0; m < NUM_CORE; m++) begin : g_match
         // conflict for a new send
         // a core returning in this same cycle no longer counts
         assign send_match[m] = active[m] && (tbl_lp[m] == send_lp) &&
                                (send_core != core_id_t'(m)) &&
                                !(ret_vld && (ret_core == core_id_t'(m)));

         // candidates for release on a return
         assign ret_match[m] = active[m] && (tbl_lp[m] == ret_lp) &&
                               (ret_core != core_id_t'(m));

         // tree leaves
         assign node_vld[NUM_CORE + m]  = ret_match[m];
         assign node_time[NUM_CORE + m] = tbl_time[m];
         assign node_id[NUM_CORE + m]   = core_id_t'(m);
      end

      // pairwise reduction toward the root
      for (genvar n = NUM_CORE - 1; n >= 1; n--) begin : g_node
         logic take_left;

         // left subtree holds the lower ids, so it wins a tie
         assign take_left = node_vld[2*n] &&
                            (!node_vld[2*n+1] || (node_time[2*n] <= node_time[2*n+1]));

         assign node_vld[n]  = node_vld[2*n] || node_vld[2*n+1];
         assign node_time[n] = take_left ? node_time[2*n] : node_time[2*n+1];
         assign node_id[n]   = take_left ? node_id[2*n] : node_id[2*n+1];
      end
   endgenerate

   // core to release on this return
   assign rel_vld = ret_vld && node_vld[1];
   assign rel_id  = node_id[1];

   // stall vector
   // new core stalls if its lp is held elsewhere
   always_ff @(posedge clk) begin
      if (reset) begin
         stall <= '0;
      end else begin
         for (int c = 0; c < NUM_CORE; c++) begin
            if (send_vld && (send_core == core_id_t'(c))) begin
               stall[c] <= |send_match;
            end else if (rel_vld && (rel_id == core_id_t'(c))) begin
               stall[c] <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/event_dispatcher.sv
// event dispatcher
`timescale 1ns/1ns
`default_nettype none

module event_dispatcher
   import pdes_event_pkg::*;
   import pdes_core_pkg::*;
#(
   parameter int NUM_CORE = 4
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  not_empty,
   input  wire lp_id_t          head_lp,
   input  wire evt_time_t       head_time,
   input  wire [NUM_CORE-1:0]   idle,
   input  wire                  ret_vld,
   output logic                 pop,
   output logic                 send_vld,
   output core_id_t             send_core,
   output lp_id_t               send_lp,
   output evt_time_t            send_time
);

   core_id_t free_core;
   logic     any_idle;
   logic     go;

   // priority encoder, lowest idle core wins
   always_comb begin
      free_core = '0;
      for (int i = NUM_CORE - 1; i >= 0; i--) begin
         if (idle[i]) begin
            free_core = core_id_t'(i);
         end
      end
   end

   assign any_idle = |idle;

   // no send while a return is on the bus
   // idle lags a send by one cycle, so wait out our own send
   assign go = not_empty && any_idle && !ret_vld && !send_vld;

   // strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         send_vld <= 1'b0;
         pop      <= 1'b0;
      end else begin
         send_vld <= go;
         // pop travels with the send
         pop      <= go;
      end
   end

   // head event plus the chosen core
   always_ff @(posedge clk) begin
      if (go) begin
         send_core <= free_core;
         send_lp   <= head_lp;
         send_time <= head_time;
      end
   end

endmodule

`default_nettype wire

// File: hdl/event_fifo.sv
// pending event buffer
`timescale 1ns/1ns
`default_nettype none

module event_fifo
   import pdes_event_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
) (
   input  wire              clk,
   input  wire              reset,
   input  wire              evt_vld,
   input  wire lp_id_t      evt_lp,
   input  wire evt_time_t   evt_time,
   input  wire              pop,
   output logic             not_empty,
   output lp_id_t           head_lp,
   output evt_time_t        head_time,
   output logic             overflow
);

   localparam int AW = $clog2(FIFO_DEPTH);

   // ring storage
   lp_id_t        mem_lp   [FIFO_DEPTH];
   evt_time_t     mem_time [FIFO_DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;

   logic          full;
   logic          wr_en;
   logic          rd_en;
   logic [AW-1:0] rd_next;
   logic [AW:0]   occ_after_pop;

   assign full  = (count == (AW+1)'(FIFO_DEPTH));
   // event is dropped when full
   assign wr_en = evt_vld && !full;
   // pop on an empty buffer has no effect
   assign rd_en = pop && not_empty;

   assign rd_next       = rd_ptr + AW'(rd_en);
   assign occ_after_pop = count - (AW+1)'(rd_en);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_lp[wr_ptr]   <= evt_lp;
         mem_time[wr_ptr] <= evt_time;
      end
   end

   // pointers, occupancy, flags
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         not_empty <= 1'b0;
         overflow  <= 1'b0;
      end else begin
         wr_ptr    <= wr_ptr + AW'(wr_en);
         rd_ptr    <= rd_next;
         count     <= occ_after_pop + (AW+1)'(wr_en);
         not_empty <= (occ_after_pop != '0) || wr_en;
         // sticky until reset
         if (evt_vld && full) begin
            overflow <= 1'b1;
         end
      end
   end

   // registered head
   // bypass the incoming event when nothing else is left
   always_ff @(posedge clk) begin
      if (occ_after_pop == '0) begin
         head_lp   <= evt_lp;
         head_time <= evt_time;
      end else begin
         head_lp   <= mem_lp[rd_next];
         head_time <= mem_time[rd_next];
      end
   end

endmodule

`default_nettype wire

// File: hdl/lp_core_array.sv
// event processing core array
`timescale 1ns/1ns
`default_nettype none

module lp_core_array
   import pdes_event_pkg::*;
   import pdes_core_pkg::*;
#(
   parameter int NUM_CORE    = 4,
   parameter int PROC_CYCLES = 6
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  send_vld,
   input  wire core_id_t        send_core,
   input  wire lp_id_t          send_lp,
   input  wire evt_time_t       send_time,
   input  wire [NUM_CORE-1:0]   stall,
   output logic [NUM_CORE-1:0]  idle,
   output logic                 ret_vld,
   output core_id_t             ret_core,
   output lp_id_t               ret_lp,
   output evt_time_t            ret_time
);

   localparam int            CW   = $clog2(PROC_CYCLES);
   localparam logic [CW-1:0] LAST = CW'(PROC_CYCLES - 1);

   core_state_t         state     [NUM_CORE];
   logic [CW-1:0]       cnt       [NUM_CORE];
   lp_id_t              core_lp   [NUM_CORE];
   evt_time_t           core_time [NUM_CORE];

   logic [NUM_CORE-1:0] done;
   logic [NUM_CORE-1:0] grant;
   core_id_t            grant_id;
   logic                grant_vld;

   // fixed priority arbiter over finished cores
   always_comb begin
      grant_id = '0;
      for (int i = NUM_CORE - 1; i >= 0; i--) begin
         if (done[i]) begin
            grant_id = core_id_t'(i);
         end
      end
   end

   assign grant_vld = |done;

   generate
      for (genvar i = 0; i < NUM_CORE; i++) begin : g_core
         logic load;

         assign load     = send_vld && (send_core == core_id_t'(i));
         assign idle[i]  = (state[i] == CORE_IDLE);
         assign done[i]  = (state[i] == CORE_DONE);
         assign grant[i] = grant_vld && (grant_id == core_id_t'(i));

         // core FSM and cycle counter
         always_ff @(posedge clk) begin
            if (reset) begin
               state[i] <= CORE_IDLE;
               cnt[i]   <= '0;
            end else begin
               case (state[i])
                  CORE_IDLE: begin
                     if (load) begin
                        state[i] <= CORE_RUN;
                        cnt[i]   <= '0;
                     end
                  end
                  CORE_RUN, CORE_STALL: begin
                     // counter frozen while held
                     if (stall[i]) begin
                        state[i] <= CORE_STALL;
                     end else if (cnt[i] == LAST) begin
                        state[i] <= CORE_DONE;
                     end else begin
                        state[i] <= CORE_RUN;
                        cnt[i]   <= cnt[i] + 1'b1;
                     end
                  end
                  CORE_DONE: begin
                     // freed on grant
                     if (grant[i]) begin
                        state[i] <= CORE_IDLE;
                     end
                  end
                  default: state[i] <= CORE_IDLE;
               endcase
            end
         end

         // event held by this core
         always_ff @(posedge clk) begin
            if (load) begin
               core_lp[i]   <= send_lp;
               core_time[i] <= send_time;
            end
         end
      end
   endgenerate

   // completion strobe, one cycle after the grant
   always_ff @(posedge clk) begin
      if (reset) begin
         ret_vld <= 1'b0;
      end else begin
         ret_vld <= grant_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (grant_vld) begin
         ret_core <= grant_id;
         ret_lp   <= core_lp[grant_id];
         ret_time <= core_time[grant_id];
      end
   end

endmodule

`default_nettype wire

// File: hdl/pdes_core_pkg.sv
// core id and state types
`default_nettype none

package pdes_core_pkg;

   // core index, 4 cores
   localparam int CORE_ID_W = 2;

   typedef logic [CORE_ID_W-1:0] core_id_t;

   // per-core FSM
   // stall is a run that is held by the monitor
   typedef enum logic [1:0] {
      CORE_IDLE  = 2'd0,
      CORE_RUN   = 2'd1,
      CORE_STALL = 2'd2,
      CORE_DONE  = 2'd3
   } core_state_t;

endpackage

`default_nettype wire

// File: hdl/pdes_engine_top.sv
// PDES event engine top
`timescale 1ns/1ns
`default_nettype none

module pdes_engine_top
   import pdes_event_pkg::*;
   import pdes_core_pkg::*;
#(
   parameter int NUM_CORE    = 4,
   parameter int FIFO_DEPTH  = 8,
   parameter int PROC_CYCLES = 6
) (
   input  wire              clk,
   input  wire              reset,
   input  wire              evt_vld,
   input  wire lp_id_t      evt_lp,
   input  wire evt_time_t   evt_time,
   output wire              done_vld,
   output wire core_id_t    done_core,
   output wire lp_id_t      done_lp,
   output wire evt_time_t   done_time,
   output wire              overflow
);

   // buffer to dispatcher
   wire                not_empty;
   wire lp_id_t        head_lp;
   wire evt_time_t     head_time;
   wire                pop;

   // dispatcher to cores and monitor
   wire                send_vld;
   wire core_id_t      send_core;
   wire lp_id_t        send_lp;
   wire evt_time_t     send_time;

   // core status
   wire [NUM_CORE-1:0] idle;
   wire [NUM_CORE-1:0] stall;

   event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .reset(reset),
      .evt_vld(evt_vld), .evt_lp(evt_lp), .evt_time(evt_time), .pop(pop),
      .not_empty(not_empty), .head_lp(head_lp), .head_time(head_time),
      .overflow(overflow)
   );

   event_dispatcher #(.NUM_CORE(NUM_CORE)) u_dispatch (
      .clk(clk), .reset(reset),
      .not_empty(not_empty), .head_lp(head_lp), .head_time(head_time),
      .idle(idle), .ret_vld(done_vld), .pop(pop),
      .send_vld(send_vld), .send_core(send_core), .send_lp(send_lp), .send_time(send_time)
   );

   // completions feed the monitor back directly
   core_monitor #(.NUM_CORE(NUM_CORE)) u_monitor (
      .clk(clk), .reset(reset),
      .send_vld(send_vld), .send_core(send_core), .send_lp(send_lp), .send_time(send_time),
      .ret_vld(done_vld), .ret_core(done_core), .ret_lp(done_lp),
      .stall(stall)
   );

   lp_core_array #(.NUM_CORE(NUM_CORE), .PROC_CYCLES(PROC_CYCLES)) u_cores (
      .clk(clk), .reset(reset),
      .send_vld(send_vld), .send_core(send_core), .send_lp(send_lp), .send_time(send_time),
      .stall(stall), .idle(idle),
      .ret_vld(done_vld), .ret_core(done_core), .ret_lp(done_lp), .ret_time(done_time)
   );

endmodule

`default_nettype wire

// File: hdl/pdes_event_pkg.sv
// event field types
`default_nettype none

package pdes_event_pkg;

   // logical process id, 8 LPs
   localparam int LP_ID_W = 3;

   // simulation timestamp width
   localparam int EVT_TIME_W = 16;

   // id of the LP an event belongs to
   typedef logic [LP_ID_W-1:0] lp_id_t;

   // event timestamp
   // smaller value means earlier in simulated time
   typedef logic [EVT_TIME_W-1:0] evt_time_t;

endpackage

`default_nettype wire

// File: list.f
hdl/pdes_event_pkg.sv
hdl/pdes_core_pkg.sv
hdl/event_fifo.sv
hdl/event_dispatcher.sv
hdl/core_monitor.sv
hdl/lp_core_array.sv
hdl/pdes_engine_top.sv
tb/tb_pdes_engine.sv

// File: tb/tb_pdes_engine.sv
// PDES engine testbench
`timescale 1ns/1ns
`default_nettype none

module tb_pdes_engine
   import pdes_event_pkg::*;
   import pdes_core_pkg::*;
();

   localparam int NUM_CORE    = 4;
   localparam int FIFO_DEPTH  = 8;
   localparam int PROC_CYCLES = 6;
   localparam int BURST_LEN   = NUM_CORE + FIFO_DEPTH + 3;
   localparam int NUM_ENT     = 10 + BURST_LEN;
   localparam int WAIT_LIMIT  = 400;

   // group tags
   localparam int G_SINGLE   = 1;
   localparam int G_PARALLEL = 2;
   localparam int G_SAME_LP  = 3;
   localparam int G_MIN_TS   = 4;
   localparam int G_BURST    = 5;

   logic      clk;
   logic      reset;
   logic      evt_vld;
   lp_id_t    evt_lp;
   evt_time_t evt_time;
   logic      done_vld;
   core_id_t  done_core;
   lp_id_t    done_lp;
   evt_time_t done_time;
   logic      overflow;

   // stimulus table
   int        tab_gap  [NUM_ENT];
   lp_id_t    tab_lp   [NUM_ENT];
   evt_time_t tab_time [NUM_ENT];
   int        tab_grp  [NUM_ENT];
   int        num_ent = 0;

   // scoreboard of accepted events
   lp_id_t    sb_lp     [NUM_ENT];
   evt_time_t sb_time   [NUM_ENT];
   int        sb_grp    [NUM_ENT];
   int        sb_strobe [NUM_ENT];
   int        sb_done   [NUM_ENT];
   logic      sb_seen   [NUM_ENT];
   int        num_acc = 0;
   int        num_done = 0;

   int        cyc = 0;
   int        errors = 0;
   int        timeouts = 0;
   int        seed = 20;
   int        hit;

   pdes_engine_top #(
      .NUM_CORE(NUM_CORE), .FIFO_DEPTH(FIFO_DEPTH), .PROC_CYCLES(PROC_CYCLES)
   ) DUT (
      .clk(clk), .reset(reset), .evt_vld(evt_vld), .evt_lp(evt_lp), .evt_time(evt_time),
      .done_vld(done_vld), .done_core(done_core), .done_lp(done_lp), .done_time(done_time),
      .overflow(overflow)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // cycle count, one per rising edge
   always @(posedge clk) cyc <= cyc + 1;

   task automatic report_mismatch(input string name, input int expected, input int actual);
      $display("CHECK FAILED at %0t ns: %s expected %0d, actual %0d",
               $time, name, expected, actual);
      errors++;
   endtask

   task automatic add_entry(input int gap, input int lp, input int tm, input int grp);
      tab_gap[num_ent]  = gap;
      tab_lp[num_ent]   = lp_id_t'(lp);
      tab_time[num_ent] = evt_time_t'(tm);
      tab_grp[num_ent]  = grp;
      num_ent++;
   endtask

   // buffer model for a one-per-cycle burst into an idle engine
   // sends leave every other cycle until every core is busy
   // the next pop waits for the first return plus the skipped return cycle
   function automatic bit burst_accepted(input int pos);
      int occ;
      bit acc;
      occ = 0;
      acc = 1'b0;
      for (int t = 0; t <= pos; t++) begin
         // full is seen before the pop of the same edge
         acc = (occ < FIFO_DEPTH);
         occ = occ + int'(acc);
         if ((t >= 2 && t <= 2 * NUM_CORE && t % 2 == 0) || t == PROC_CYCLES + 6) begin
            occ--;
         end
      end
      return acc;
   endfunction

   // wait until every accepted event has completed
   task automatic wait_drain();
      int waited;
      waited = 0;
      while (num_done < num_acc && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (num_done < num_acc) begin
         $display("timeout at %0t ns: %0d of %0d accepted events never completed",
                  $time, num_acc - num_done, num_acc);
         timeouts++;
      end
   endtask

   // checks on one drained group
   task automatic check_group(input int g);
      int first;
      int diff;
      int exp_early;
      int act_early;
      int bound;
      first = -1;
      // the last of the parallel events is sent 2*(NUM_CORE-1) cycles after the first
      bound = PROC_CYCLES + 4 + 2 * (NUM_CORE - 1);
      if (overflow !== (g == G_BURST)) begin
         report_mismatch("overflow", g == G_BURST, overflow);
      end
      for (int i = 0; i < num_acc; i++) begin
         if (sb_grp[i] == g && sb_seen[i]) begin
            if (first < 0) begin
               first = i;
            end
            if (g == G_SINGLE && sb_done[i] - sb_strobe[i] != PROC_CYCLES + 4) begin
               report_mismatch("done_vld latency", PROC_CYCLES + 4, sb_done[i] - sb_strobe[i]);
            end
            if (g == G_PARALLEL && sb_done[i] - sb_strobe[first] > bound) begin
               report_mismatch("done_vld cycles from first strobe", bound,
                               sb_done[i] - sb_strobe[first]);
            end
            for (int j = i + 1; j < num_acc; j++) begin
               if (sb_grp[j] == g && sb_seen[j]) begin
                  diff = sb_done[j] - sb_done[i];
                  // one lp never runs on two cores at once
                  if (g == G_SAME_LP && diff < PROC_CYCLES && diff > -PROC_CYCLES) begin
                     report_mismatch("done_vld spacing", PROC_CYCLES, diff < 0 ? -diff : diff);
                  end
                  // first sent runs first, held ones follow by smallest timestamp
                  if (g == G_MIN_TS) begin
                     exp_early = (i == first || sb_time[i] < sb_time[j]) ? i : j;
                     act_early = (diff > 0) ? i : j;
                     if (exp_early != act_early) begin
                        report_mismatch("done_time of earlier completion",
                                        sb_time[exp_early], sb_time[act_early]);
                     end
                  end
               end
            end
         end
      end
   endtask

   // completion monitor, outputs settled on the falling edge
   always @(negedge clk) begin
      if (!reset && done_vld === 1'b1) begin
         hit = -1;
         for (int k = 0; k < num_acc; k++) begin
            if (hit < 0 && !sb_seen[k] &&
                sb_lp[k] == done_lp && sb_time[k] == done_time) begin
               hit = k;
            end
         end
         if (hit < 0) begin
            $display("at %0t ns: completion of lp %0d time %0d matches no pending event",
                     $time, done_lp, done_time);
            errors++;
         end else begin
            sb_seen[hit] = 1'b1;
            sb_done[hit] = cyc;
            num_done++;
            // idle engine hands the event to core 0
            if (sb_grp[hit] == G_SINGLE && done_core != 0) begin
               report_mismatch("done_core", 0, done_core);
            end
         end
      end
   end

   initial begin
      int r_lp;
      int r_tm;
      int burst_pos;
      evt_vld   = 1'b0;
      evt_lp    = '0;
      evt_time  = '0;
      reset     = 1'b1;
      burst_pos = 0;
      for (int k = 0; k < NUM_ENT; k++) begin
         sb_seen[k] = 1'b0;
      end

      // gap cycles, lp, timestamp, group
      add_entry(2, 5, 100, G_SINGLE);
      add_entry(2, 1, 300, G_PARALLEL);
      add_entry(0, 2, 310, G_PARALLEL);
      add_entry(0, 3, 320, G_PARALLEL);
      add_entry(0, 4, 330, G_PARALLEL);
      add_entry(2, 6, 200, G_SAME_LP);
      add_entry(0, 6, 210, G_SAME_LP);
      add_entry(2, 7, 50, G_MIN_TS);
      add_entry(0, 7, 30, G_MIN_TS);
      add_entry(0, 7, 40, G_MIN_TS);
      // burst with random lp and timestamp
      for (int k = 0; k < BURST_LEN; k++) begin
         r_lp = $random(seed);
         r_tm = $random(seed);
         add_entry(k == 0 ? 2 : 0, r_lp, r_tm, G_BURST);
      end

      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (done_vld !== 1'b0) begin
         report_mismatch("done_vld", 0, done_vld);
      end
      if (overflow !== 1'b0) begin
         report_mismatch("overflow", 0, overflow);
      end

      for (int i = 0; i < num_ent; i++) begin
         // previous group drains before the next starts
         if (i > 0 && tab_grp[i] != tab_grp[i-1]) begin
            @(negedge clk);
            evt_vld = 1'b0;
            wait_drain();
            check_group(tab_grp[i-1]);
         end
         repeat (tab_gap[i]) begin
            @(negedge clk);
            evt_vld = 1'b0;
         end
         @(negedge clk);
         evt_vld  = 1'b1;
         evt_lp   = tab_lp[i];
         evt_time = tab_time[i];
         // only the burst can meet a full buffer
         if (tab_grp[i] != G_BURST || burst_accepted(burst_pos)) begin
            sb_lp[num_acc]     = tab_lp[i];
            sb_time[num_acc]   = tab_time[i];
            sb_grp[num_acc]    = tab_grp[i];
            sb_strobe[num_acc] = cyc;
            num_acc++;
         end
         if (tab_grp[i] == G_BURST) begin
            burst_pos++;
         end
      end
      @(negedge clk);
      evt_vld = 1'b0;
      wait_drain();

      // quiet window, a late completion here is an extra one
      repeat (4 * PROC_CYCLES) @(negedge clk);
      check_group(G_BURST);
      if (num_done != num_acc) begin
         report_mismatch("completion count", num_acc, num_done);
      end

      $display("errors: %0d failed checks, %0d timeouts, %0d of %0d accepted events done",
               errors, timeouts, num_done, num_acc);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
